/* common/na_pkg.sv */
// Flit kind encoding follows the mesh link convention; the address map decodes bits 21:20 and 3:2 only
package na_pkg;

   // Flit layout
   localparam int flit_data_w = 32;

   typedef enum logic [1:0] {
      kind_payload = 2'b00,                    // Body of a packet
      kind_header  = 2'b01,                    // Opens a multi-flit packet
      kind_last    = 2'b10,                    // Closes a packet
      kind_single  = 2'b11                     // One-flit packet
   } flit_kind_t;

   typedef struct packed {
      flit_kind_t             kind;            // Top two bits
      logic [flit_data_w-1:0] data;
   } noc_flit_t;                               // 34 bits on the link

   // Bus address map
   localparam int bus_adr_w = 24;

   localparam logic [1:0] region_conf = 2'd0;  // Bits 21:20, base + 0x000000
   localparam logic [1:0] region_mp0  = 2'd1;  // Base + 0x100000
   localparam logic [1:0] region_mp1  = 2'd2;  // Base + 0x200000, value 3 unmapped

   // Configuration words, bits 3:2
   localparam logic [1:0] conf_tile_id   = 2'd0;
   localparam logic [1:0] conf_xdim      = 2'd1;
   localparam logic [1:0] conf_ydim      = 2'd2;
   localparam logic [1:0] conf_vchannels = 2'd3;

   // Endpoint registers, bits 3:2
   localparam logic [1:0] mp_reg_send   = 2'd0;  // Length word, then N data words
   localparam logic [1:0] mp_reg_recv   = 2'd1;  // Pops one flit per read
   localparam logic [1:0] mp_reg_status = 2'd2;  // Fill counts and overflow

endpackage

/* common/na_bus_if.sv */
// Single-beat cyc/stb/ack slave bus; no byte selects, bursts or retry
interface na_bus_if;

   logic                        cyc;
   logic                        stb;   // Raised to the selected slave only
   logic                        we;
   logic [na_pkg::bus_adr_w-1:0] adr;
   logic [na_pkg::flit_data_w-1:0] wdat;
   logic [na_pkg::flit_data_w-1:0] rdat;  // Valid with ack
   logic                        ack;   // Registered in the slave

   modport master (
      output cyc,
      output stb,
      output we,
      output adr,
      output wdat,
      input  rdat,
      input  ack
   );

   modport slave (
      input  cyc,
      input  stb,
      input  we,
      input  adr,
      input  wdat,
      output rdat,
      output ack
   );

endinterface

/* rtl/na_fifo.sv */
// Show-ahead flit queue; the user must not push when full or pop when empty
module na_fifo #(
   parameter int fifo_depth = 8
) (
   input  logic                              clk,
   input  logic                              reset_i,
   input  logic                              push_i,
   input  na_pkg::noc_flit_t                 push_data_i,
   output logic                              full_o,
   input  logic                              pop_i,
   output na_pkg::noc_flit_t                 pop_data_o,
   output logic                              empty_o,
   output logic [$clog2(fifo_depth+1)-1:0]   count_o
);

   localparam int aw = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
   localparam int cw = $clog2(fifo_depth + 1);

   na_pkg::noc_flit_t mem [fifo_depth];
   logic [aw-1:0]     wr_ptr, rd_ptr;
   logic [cw-1:0]     count_q;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count_q <= '0;
      end else begin
         if (push_i)
            wr_ptr <= (wr_ptr == aw'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap at depth
         if (pop_i)
            rd_ptr <= (rd_ptr == aw'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
         count_q <= count_q + cw'(push_i) - cw'(pop_i);
      end
   end

   always_ff @(posedge clk) begin
      if (push_i)
         mem[wr_ptr] <= push_data_i;
   end

   assign pop_data_o = mem[rd_ptr];                  // Head visible before pop
   assign full_o     = (count_q == cw'(fifo_depth));
   assign empty_o    = (count_q == '0);
   assign count_o    = count_q;

   // Callers gate their strobes with the flags
   a_no_overflow: assert property (@(posedge clk) disable iff (reset_i)
      full_o |-> !push_i || pop_i);
   a_no_underflow: assert property (@(posedge clk) disable iff (reset_i)
      empty_o |-> !pop_i);

endmodule

/* mp_simple/na_mp_simple.sv */
// One virtual channel endpoint; a send length of 0 is ignored, a dropped word still counts
module na_mp_simple #(
   parameter int fifo_depth = 8
) (
   input  logic              clk,
   input  logic              reset_i,
   na_bus_if.slave           bus,
   input  na_pkg::noc_flit_t noc_in_flit_i,
   input  logic              noc_in_valid_i,
   output logic              noc_in_ready_o,
   output na_pkg::noc_flit_t noc_out_flit_o,
   output logic              noc_out_valid_o,
   input  logic              noc_out_ready_i,
   output logic              irq_o
);

   logic [$clog2(fifo_depth+1)-1:0] rx_count, tx_count;
   na_pkg::noc_flit_t               rx_flit, tx_push_flit;
   logic                            rx_full, rx_empty, rx_pop;
   logic                            tx_full, tx_empty, tx_push;
   logic                            ack_q, irq_q, overflow_q, first_q;
   logic [3:0]                      rem_q;
   logic [na_pkg::flit_data_w-1:0]  rdat_q;
   logic                            acc, wr_send, rd_recv;

   assign acc     = bus.cyc & bus.stb & ~ack_q;  // First cycle of a strobe
   assign wr_send = acc & bus.we & (bus.adr[3:2] == na_pkg::mp_reg_send) & (rem_q != 4'd0);
   assign rd_recv = acc & ~bus.we & (bus.adr[3:2] == na_pkg::mp_reg_recv);

   // Tag by position in the packet
   always_comb begin
      if (first_q)
         tx_push_flit.kind = (rem_q == 4'd1) ? na_pkg::kind_single : na_pkg::kind_header;
      else
         tx_push_flit.kind = (rem_q == 4'd1) ? na_pkg::kind_last : na_pkg::kind_payload;
   end
   assign tx_push_flit.data = bus.wdat;
   assign tx_push = wr_send & ~tx_full;          // Word lost when full
   assign rx_pop  = rd_recv & ~rx_empty;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ack_q      <= 1'b0;
         irq_q      <= 1'b0;
         overflow_q <= 1'b0;
         rem_q      <= 4'd0;
         first_q    <= 1'b0;
      end else begin
         ack_q <= acc;                          // Ack one clock after stb
         irq_q <= ~rx_empty;
         if (acc && bus.we && bus.adr[3:2] == na_pkg::mp_reg_send && rem_q == 4'd0) begin
            rem_q   <= bus.wdat[3:0];           // Length word opens a packet
            first_q <= 1'b1;
         end else if (wr_send) begin
            rem_q   <= rem_q - 4'd1;
            first_q <= 1'b0;
            if (tx_full)
               overflow_q <= 1'b1;              // Sticky
         end
      end
   end

   // Read data lands with ack
   always_ff @(posedge clk) begin
      if (acc && !bus.we) begin
         case (bus.adr[3:2])
            na_pkg::mp_reg_recv:   rdat_q <= rx_empty ? '0 : rx_flit.data;
            na_pkg::mp_reg_status: rdat_q <= {15'd0, overflow_q, 8'(tx_count), 8'(rx_count)};
            default:               rdat_q <= '0;
         endcase
      end
   end

   assign bus.ack  = ack_q;
   assign bus.rdat = rdat_q;
   assign irq_o    = irq_q;

   na_fifo #(
      .fifo_depth (fifo_depth)
   ) u_tx_fifo (
      .clk         (clk),
      .reset_i     (reset_i),
      .push_i      (tx_push),
      .push_data_i (tx_push_flit),
      .full_o      (tx_full),
      .pop_i       (noc_out_valid_o & noc_out_ready_i),
      .pop_data_o  (noc_out_flit_o),
      .empty_o     (tx_empty),
      .count_o     (tx_count)
   );

   na_fifo #(
      .fifo_depth (fifo_depth)
   ) u_rx_fifo (
      .clk         (clk),
      .reset_i     (reset_i),
      .push_i      (noc_in_valid_i & ~rx_full),
      .push_data_i (noc_in_flit_i),
      .full_o      (rx_full),
      .pop_i       (rx_pop),
      .pop_data_o  (rx_flit),
      .empty_o     (rx_empty),
      .count_o     (rx_count)
   );

   assign noc_out_valid_o = ~tx_empty;
   assign noc_in_ready_o  = ~rx_full;           // Back-pressure into the link

   // Stalled flit must not change under the arbiter
   a_out_stable: assert property (@(posedge clk) disable iff (reset_i)
      noc_out_valid_o && !noc_out_ready_i |=> noc_out_valid_o && $stable(noc_out_flit_o));

endmodule

/* rtl/na_conf.sv */
// Read-only tile identity block; writes are acknowledged and discarded
module na_conf #(
   parameter int tile_id   = 0,
   parameter int noc_xdim  = 4,
   parameter int noc_ydim  = 4,
   parameter int vchannels = 2
) (
   input  logic    clk,
   input  logic    reset_i,
   na_bus_if.slave bus
);

   logic                           ack_q;
   logic [na_pkg::flit_data_w-1:0] rdat_q;

   always_ff @(posedge clk) begin
      if (reset_i)
         ack_q <= 1'b0;
      else
         ack_q <= bus.cyc & bus.stb & ~ack_q;   // One clock after stb
   end

   always_ff @(posedge clk) begin
      if (bus.cyc && bus.stb && !ack_q && !bus.we) begin
         case (bus.adr[3:2])
            na_pkg::conf_tile_id:   rdat_q <= 32'(tile_id);
            na_pkg::conf_xdim:      rdat_q <= 32'(noc_xdim);
            na_pkg::conf_ydim:      rdat_q <= 32'(noc_ydim);
            na_pkg::conf_vchannels: rdat_q <= 32'(vchannels);
            default:                rdat_q <= '0;
         endcase
      end
   end

   assign bus.ack  = ack_q;
   assign bus.rdat = rdat_q;

endmodule

/* rtl/na_bus_decode.sv */
// Three-slave decoder on address bits 21:20; region 3 answers err and never reaches a slave
module na_bus_decode (
   input  logic                           clk,
   input  logic                           reset_i,
   input  logic                           bus_cyc_i,
   input  logic                           bus_stb_i,
   input  logic                           bus_we_i,
   input  logic [na_pkg::bus_adr_w-1:0]   bus_adr_i,
   input  logic [na_pkg::flit_data_w-1:0] bus_dat_i,
   output logic [na_pkg::flit_data_w-1:0] bus_dat_o,
   output logic                           bus_ack_o,
   output logic                           bus_err_o,
   na_bus_if.master                       conf,
   na_bus_if.master                       mp0,
   na_bus_if.master                       mp1
);

   logic sel_conf, sel_mp0, sel_mp1, unmapped;
   logic err_q;

   assign sel_conf = (bus_adr_i[21:20] == na_pkg::region_conf);
   assign sel_mp0  = (bus_adr_i[21:20] == na_pkg::region_mp0);
   assign sel_mp1  = (bus_adr_i[21:20] == na_pkg::region_mp1);
   assign unmapped = ~(sel_conf | sel_mp0 | sel_mp1);

   // Request fans out and strobe goes to one slave
   assign conf.cyc  = bus_cyc_i;
   assign conf.stb  = bus_stb_i & sel_conf;
   assign conf.we   = bus_we_i;
   assign conf.adr  = bus_adr_i;
   assign conf.wdat = bus_dat_i;
   assign mp0.cyc   = bus_cyc_i;
   assign mp0.stb   = bus_stb_i & sel_mp0;
   assign mp0.we    = bus_we_i;
   assign mp0.adr   = bus_adr_i;
   assign mp0.wdat  = bus_dat_i;
   assign mp1.cyc   = bus_cyc_i;
   assign mp1.stb   = bus_stb_i & sel_mp1;
   assign mp1.we    = bus_we_i;
   assign mp1.adr   = bus_adr_i;
   assign mp1.wdat  = bus_dat_i;

   always_ff @(posedge clk) begin
      if (reset_i)
         err_q <= 1'b0;
      else
         err_q <= bus_cyc_i & bus_stb_i & unmapped & ~err_q;  // Same timing as a slave ack
   end

   assign bus_ack_o = (sel_conf & conf.ack) | (sel_mp0 & mp0.ack) | (sel_mp1 & mp1.ack);
   assign bus_err_o = err_q;
   assign bus_dat_o = sel_mp0 ? mp0.rdat :
                      sel_mp1 ? mp1.rdat :
                      conf.rdat;

   // Slave ack and decoder err on the same cycle would mean a leaked strobe
   a_ack_err: assert property (@(posedge clk) disable iff (reset_i)
      !(bus_ack_o && bus_err_o));

endmodule

/* rtl/na_out_arbiter.sv */
// Packet-preserving round robin; needs vchannels >= 2 and well-formed header..last sequences
module na_out_arbiter #(
   parameter int vchannels = 2
) (
   input  logic                   clk,
   input  logic                   reset_i,
   input  na_pkg::noc_flit_t      in_flit_i [vchannels],
   input  logic [vchannels-1:0]   in_valid_i,
   output logic [vchannels-1:0]   in_ready_o,
   output na_pkg::noc_flit_t      link_flit_o,
   output logic [vchannels-1:0]   link_valid_o,
   input  logic [vchannels-1:0]   link_ready_i
);

   localparam int cw = $clog2(vchannels);

   logic [cw-1:0] ptr_q;     // Last channel served and owner while locked
   logic          lock_q;
   logic [cw-1:0] gnt, cand;
   logic          gnt_vld, xfer;

   always_comb begin
      gnt     = ptr_q;
      gnt_vld = 1'b0;
      cand    = ptr_q;
      if (lock_q) begin
         gnt_vld = in_valid_i[ptr_q];            // Hold the packet owner
      end else begin
         for (int i = 1; i <= vchannels; i++) begin
            cand = cw'((int'(ptr_q) + i) % vchannels);
            if (!gnt_vld && in_valid_i[cand]) begin
               gnt     = cand;
               gnt_vld = 1'b1;
            end
         end
      end
   end

   assign xfer        = gnt_vld & link_ready_i[gnt];
   assign link_flit_o = in_flit_i[gnt];

   always_comb begin
      link_valid_o      = '0;
      in_ready_o        = '0;
      link_valid_o[gnt] = gnt_vld;
      in_ready_o[gnt]   = xfer;
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         ptr_q  <= cw'(vchannels - 1);          // Channel 0 first
         lock_q <= 1'b0;
      end else if (xfer) begin
         ptr_q <= gnt;
         if (in_flit_i[gnt].kind == na_pkg::kind_header)
            lock_q <= 1'b1;
         else if (in_flit_i[gnt].kind == na_pkg::kind_last)
            lock_q <= 1'b0;
      end
   end

   // A packet opens while unlocked and continues while locked
   a_packet_framing: assert property (@(posedge clk) disable iff (reset_i)
      xfer |-> lock_q == (in_flit_i[gnt].kind inside {na_pkg::kind_payload, na_pkg::kind_last}));

endmodule

/* rtl/networkadapter_ct.sv */
// Compute tile adapter with two endpoints on vchannels 0 and 1; vchannels must be 2
module networkadapter_ct #(
   parameter int tile_id    = 0,
   parameter int noc_xdim   = 4,
   parameter int noc_ydim   = 4,
   parameter int fifo_depth = 8,
   parameter int vchannels  = 2
) (
   input  logic                           clk,
   input  logic                           reset_i,
   input  logic                           bus_cyc_i,
   input  logic                           bus_stb_i,
   input  logic                           bus_we_i,
   input  logic [na_pkg::bus_adr_w-1:0]   bus_adr_i,
   input  logic [na_pkg::flit_data_w-1:0] bus_dat_i,
   output logic [na_pkg::flit_data_w-1:0] bus_dat_o,
   output logic                           bus_ack_o,
   output logic                           bus_err_o,
   input  na_pkg::noc_flit_t              noc_in_flit_i,
   input  logic [vchannels-1:0]           noc_in_valid_i,
   output logic [vchannels-1:0]           noc_in_ready_o,
   output na_pkg::noc_flit_t              noc_out_flit_o,
   output logic [vchannels-1:0]           noc_out_valid_o,
   input  logic [vchannels-1:0]           noc_out_ready_i,
   output logic [1:0]                     irq_o
);

   na_bus_if conf_bus ();
   na_bus_if mp_bus [2] ();

   na_pkg::noc_flit_t    mod_out_flit [vchannels];
   logic [vchannels-1:0] mod_out_valid;
   logic [vchannels-1:0] mod_out_ready;

   na_bus_decode u_decode (
      .clk       (clk),
      .reset_i   (reset_i),
      .bus_cyc_i (bus_cyc_i),
      .bus_stb_i (bus_stb_i),
      .bus_we_i  (bus_we_i),
      .bus_adr_i (bus_adr_i),
      .bus_dat_i (bus_dat_i),
      .bus_dat_o (bus_dat_o),
      .bus_ack_o (bus_ack_o),
      .bus_err_o (bus_err_o),
      .conf      (conf_bus),
      .mp0       (mp_bus[0]),
      .mp1       (mp_bus[1])
   );

   na_conf #(
      .tile_id   (tile_id),
      .noc_xdim  (noc_xdim),
      .noc_ydim  (noc_ydim),
      .vchannels (vchannels)
   ) u_conf (
      .clk     (clk),
      .reset_i (reset_i),
      .bus     (conf_bus)
   );

   // Endpoint v owns virtual channel v
   for (genvar v = 0; v < 2; v++) begin : g_mp
      na_mp_simple #(
         .fifo_depth (fifo_depth)
      ) u_mp_simple (
         .clk             (clk),
         .reset_i         (reset_i),
         .bus             (mp_bus[v]),
         .noc_in_flit_i   (noc_in_flit_i),
         .noc_in_valid_i  (noc_in_valid_i[v]),
         .noc_in_ready_o  (noc_in_ready_o[v]),
         .noc_out_flit_o  (mod_out_flit[v]),
         .noc_out_valid_o (mod_out_valid[v]),
         .noc_out_ready_i (mod_out_ready[v]),
         .irq_o           (irq_o[v])
      );
   end

   na_out_arbiter #(
      .vchannels (vchannels)
   ) u_arb (
      .clk          (clk),
      .reset_i      (reset_i),
      .in_flit_i    (mod_out_flit),
      .in_valid_i   (mod_out_valid),
      .in_ready_o   (mod_out_ready),
      .link_flit_o  (noc_out_flit_o),
      .link_valid_o (noc_out_valid_o),
      .link_ready_i (noc_out_ready_i)
   );

endmodule

/* tb/tb_networkadapter_ct.sv */
// Directed checks sized for fifo_depth 8 and two channels; payload words come from a 16-bit LFSR
module tb_networkadapter_ct;
   timeunit 1ns;
   timeprecision 100ps;

   logic                           clk = 1'b0;
   logic                           reset_i;
   logic                           bus_cyc_i, bus_stb_i, bus_we_i;
   logic [na_pkg::bus_adr_w-1:0]   bus_adr_i;
   logic [na_pkg::flit_data_w-1:0] bus_dat_i, bus_dat_o;
   logic                           bus_ack_o, bus_err_o;
   na_pkg::noc_flit_t              noc_in_flit_i, noc_out_flit_o;
   logic [1:0]                     noc_in_valid_i, noc_in_ready_o;
   logic [1:0]                     noc_out_valid_o, noc_out_ready_i, irq_o;

   int          errors = 0;
   logic [15:0] lfsr_q = 16'd97;                // Seed
   logic [31:0] exp0[$], exp1[$], src_q[$];     // Words written per endpoint and words driven in
   int          got_ch[$];                      // Channel of each collected flit
   logic [33:0] got_flit[$];
   logic [31:0] rd;
   logic        ack, err;
   int          sw, t;

   always #50 clk = ~clk;                       // 100 ns period

   networkadapter_ct #(
      .tile_id    (5),
      .noc_xdim   (4),
      .noc_ydim   (2),
      .fifo_depth (8)
   ) networkadapter_ct_i (.*);

   // Taps 16,14,13,11
   function automatic logic lfsr_bit();
      logic fb;
      fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      return fb;
   endfunction

   function automatic logic [31:0] rand_word();
      logic [31:0] w;
      w = '0;
      for (int i = 0; i < 32; i++)
         w = {w[30:0], lfsr_bit()};             // One step per bit
      return w;
   endfunction

   // Kind of flit i in an n-flit packet
   function automatic logic [1:0] tag_kind(input int i, input int n);
      if (n == 1) return na_pkg::kind_single;
      if (i == 0) return na_pkg::kind_header;
      if (i == n - 1) return na_pkg::kind_last;
      return na_pkg::kind_payload;
   endfunction

   task automatic check_value(input string name, input logic [33:0] got, input logic [33:0] exp);
      if (got !== exp) begin
         errors++;
         $display("FAIL %s: got %h expected %h", name, got, exp);
      end
   endtask

   task automatic bus_cycle(input logic we, input logic [23:0] adr, input logic [31:0] wdat,
                            output logic [31:0] rdat, output logic a, output logic e);
      int n;
      @(posedge clk);
      #10;
      bus_cyc_i = 1'b1;
      bus_stb_i = 1'b1;
      bus_we_i  = we;
      bus_adr_i = adr;
      bus_dat_i = wdat;
      for (n = 0; n < 20; n++) begin
         @(negedge clk);
         if (bus_ack_o || bus_err_o) break;
      end
      a    = bus_ack_o;
      e    = bus_err_o;
      rdat = bus_dat_o;                         // Valid with ack
      if (n == 20) begin
         errors++;
         $display("Bus cycle to address %h got neither ack nor err", adr);
      end
      @(posedge clk);
      #10;
      bus_cyc_i = 1'b0;                         // Stb low at least one cycle
      bus_stb_i = 1'b0;
      bus_we_i  = 1'b0;
   endtask

   task automatic bus_write(input logic [23:0] adr, input logic [31:0] dat);
      logic [31:0] d;
      logic        a, e;
      bus_cycle(1'b1, adr, dat, d, a, e);
      check_value("bus_ack_o", a, 1'b1);
   endtask

   task automatic bus_read(input logic [23:0] adr, output logic [31:0] dat);
      logic a, e;
      bus_cycle(1'b0, adr, '0, dat, a, e);
      check_value("bus_ack_o", a, 1'b1);
   endtask

   // Length word then n LFSR words into endpoint ch
   task automatic send_packet(input int ch, input int n);
      logic [23:0] base;
      logic [31:0] w;
      base = (ch == 0) ? 24'h100000 : 24'h200000;
      bus_write(base, n);
      for (int i = 0; i < n; i++) begin
         w = rand_word();
         if (ch == 0) exp0.push_back(w);
         else exp1.push_back(w);
         bus_write(base, w);
      end
   endtask

   // Link sink with ready mask rdy while collecting n flits
   task automatic collect_flits(input int n, input logic [1:0] rdy);
      int m;
      got_ch.delete();
      got_flit.delete();
      @(posedge clk);
      #10 noc_out_ready_i = rdy;
      for (m = 0; m < 200 && got_flit.size() < n; m++) begin
         @(negedge clk);
         if (|(noc_out_valid_o & noc_out_ready_i)) begin  // Transfers on next edge
            got_ch.push_back(noc_out_valid_o[1] ? 1 : 0);
            got_flit.push_back(noc_out_flit_o);
         end
      end
      if (got_flit.size() < n) begin
         errors++;
         $display("Outbound link delivered %0d of %0d flits", got_flit.size(), n);
      end
      @(posedge clk);
      #10 noc_out_ready_i = 2'b00;
   endtask

   task automatic check_packet(input int ch, input int n);
      int          k;
      logic [31:0] exp;
      k = 0;
      for (int i = 0; i < got_flit.size(); i++) begin
         if (got_ch[i] == ch && k < n) begin
            if (ch == 0) exp = exp0.pop_front();
            else exp = exp1.pop_front();
            check_value("noc_out_flit_o.kind", got_flit[i][33:32], tag_kind(k, n));
            check_value("noc_out_flit_o.data", got_flit[i][31:0], exp);
            k++;
         end
      end
      check_value("noc_out_valid_o count", k, n);
   endtask

   // Link source driving one packet of n flits into channel ch
   task automatic drive_flits(input int ch, input int n);
      int          m;
      logic [31:0] w;
      for (int i = 0; i < n; i++) begin
         w = rand_word();
         src_q.push_back(w);
         @(posedge clk);
         #10;
         noc_in_flit_i      = {tag_kind(i, n), w};
         noc_in_valid_i[ch] = 1'b1;
         for (m = 0; m < 50; m++) begin
            @(negedge clk);
            if (noc_in_ready_o[ch]) break;       // Accepted on next edge
         end
         if (m == 50) begin
            errors++;
            $display("Channel %0d never accepted inbound flit %0d", ch, i);
         end
      end
      @(posedge clk);
      #10 noc_in_valid_i[ch] = 1'b0;
   endtask

   initial begin
      reset_i = 1'b1;
      {bus_cyc_i, bus_stb_i, bus_we_i} = '0;
      bus_adr_i       = '0;
      bus_dat_i       = '0;
      noc_in_flit_i   = '0;
      noc_in_valid_i  = '0;
      noc_out_ready_i = '0;
      repeat (10) @(posedge clk);
      #10 reset_i = 1'b0;
      @(negedge clk);
      check_value("bus_ack_o", bus_ack_o, 0);   // Reset state
      check_value("bus_err_o", bus_err_o, 0);
      check_value("noc_out_valid_o", noc_out_valid_o, 0);
      check_value("irq_o", irq_o, 0);
      check_value("noc_in_ready_o", noc_in_ready_o, 2'b11);

      bus_read(24'h000000, rd);                 // Configuration block
      check_value("bus_dat_o tile_id", rd, 5);
      bus_read(24'h000004, rd);
      check_value("bus_dat_o xdim", rd, 4);
      bus_read(24'h000008, rd);
      check_value("bus_dat_o ydim", rd, 2);
      bus_read(24'h00000c, rd);
      check_value("bus_dat_o vchannels", rd, 2);
      bus_cycle(1'b0, 24'h300000, '0, rd, ack, err);  // Unmapped region
      check_value("bus_err_o", err, 1);
      check_value("bus_ack_o", ack, 0);

      send_packet(0, 3);                        // Header, payload, last
      collect_flits(3, 2'b11);
      check_packet(0, 3);
      check_value("noc_out_valid_o channel", got_ch[0], 0);
      send_packet(0, 1);
      collect_flits(1, 2'b11);
      check_packet(0, 1);

      src_q.delete();
      drive_flits(1, 3);
      for (t = 0; t < 20 && !irq_o[1]; t++)
         @(negedge clk);
      check_value("irq_o", irq_o, 2'b10);
      bus_read(24'h200008, rd);
      check_value("bus_dat_o status", rd, 32'h3);
      for (int i = 0; i < 3; i++) begin
         bus_read(24'h200004, rd);
         check_value("bus_dat_o recv", rd, src_q[i]);
      end
      @(negedge clk);
      check_value("irq_o", irq_o, 2'b00);

      send_packet(0, 3);                        // Both queued behind a stalled link
      send_packet(1, 2);
      @(negedge clk);
      check_value("noc_out_valid_o pending", noc_out_valid_o != 0, 1);
      collect_flits(5, 2'b11);
      check_packet(0, 3);
      check_packet(1, 2);
      sw = 0;
      for (int i = 1; i < got_ch.size(); i++)
         if (got_ch[i] != got_ch[i-1]) sw++;
      if (sw > 1) begin
         errors++;
         $display("Packets of the two channels interleaved on the outbound link");
      end

      src_q.delete();
      fork
         drive_flits(0, 9);                     // Ninth waits on a full receive queue
         begin
            for (t = 0; t < 50 && noc_in_ready_o[0]; t++)
               @(negedge clk);
            check_value("noc_in_ready_o", noc_in_ready_o, 2'b10);
            bus_read(24'h100004, rd);           // Frees one slot for the ninth
            check_value("bus_dat_o recv", rd, src_q[0]);
         end
      join
      bus_read(24'h100008, rd);
      check_value("bus_dat_o status", rd, 32'h8);
      for (int i = 1; i < 9; i++) begin
         bus_read(24'h100004, rd);
         check_value("bus_dat_o recv", rd, src_q[i]);
      end

      $display("Errors: %0d", errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

/* project.f */
common/na_pkg.sv
common/na_bus_if.sv
rtl/na_fifo.sv
mp_simple/na_mp_simple.sv
rtl/na_conf.sv
rtl/na_bus_decode.sv
rtl/na_out_arbiter.sv
rtl/networkadapter_ct.sv
tb/tb_networkadapter_ct.sv
